/* source/mem_pkg.sv */
package mem_pkg;

    // widths with a meaning
    typedef logic [31:0] word_t;    // data word, also used for addresses
    typedef logic [3:0]  strb_t;    // byte-write strobe, bit n = lane n

    // memory op codes from the control unit
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,             // no memory access
        OP_LB   = 4'd1,             // load byte, sign extended
        OP_LH   = 4'd2,             // load half, sign extended
        OP_LW   = 4'd3,             // load word
        OP_LBU  = 4'd4,             // load byte, zero extended
        OP_LHU  = 4'd5,             // load half, zero extended
        OP_SB   = 4'd6,             // store byte
        OP_SH   = 4'd7,             // store half
        OP_SW   = 4'd8              // store word
    } mem_op_t;

    // store strobes, data always in the low lanes
    localparam strb_t STRB_BYTE = 4'b0001;
    localparam strb_t STRB_HALF = 4'b0011;
    localparam strb_t STRB_WORD = 4'b1111;

    // request buffer sizing
    localparam int FIFO_DEPTH = 4;          // entries held
    localparam int PTR_W      = 2;          // log2 of depth
    localparam int CNT_W      = PTR_W + 1;  // count reaches FIFO_DEPTH

    // handler phases
    typedef enum logic [1:0] {
        FETCH  = 2'd0,              // push instruction read
        F_WAIT = 2'd1,              // wait for instruction word
        DATA   = 2'd2,              // issue load/store of this instr
        D_WAIT = 2'd3               // wait for load data
    } handler_state_t;

    // apb master phases
    typedef enum logic [1:0] {
        IDLE   = 2'd0,              // nothing on the bus
        SETUP  = 2'd1,              // psel high, penable low
        ACCESS = 2'd2               // psel and penable high until pready
    } apb_state_t;

endpackage

/* source/mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if (
    input logic clk
);
    import mem_pkg::*;

    // handler -> fifo
    logic  push_valid;
    logic  push_ready;
    logic  push_write;      // 1 = store, 0 = read
    word_t push_addr;
    word_t push_wdata;
    strb_t push_strb;

    // fifo -> apb master
    logic  pop_valid;
    logic  pop_ready;
    logic  pop_write;
    word_t pop_addr;
    word_t pop_wdata;
    strb_t pop_strb;

    // read data back to handler, one pulse per read
    logic  rsp_valid;
    word_t rsp_rdata;

    modport producer (
        input  clk, push_ready, rsp_valid, rsp_rdata,
        output push_valid, push_write, push_addr, push_wdata, push_strb
    );

    modport buffer (
        input  clk, push_valid, push_write, push_addr, push_wdata, push_strb, pop_ready,
        output push_ready, pop_valid, pop_write, pop_addr, pop_wdata, pop_strb
    );

    modport consumer (
        input  clk, pop_valid, pop_write, pop_addr, pop_wdata, pop_strb,
        output pop_ready, rsp_valid, rsp_rdata
    );

endinterface

/* source/mem_handler.sv */
`timescale 1ns/1ps

module mem_handler (
    input  logic             clk,
    input  logic             nrst,
    input  mem_pkg::word_t   pc_i,          // fetch address
    input  mem_pkg::mem_op_t mem_op_i,      // op code from control unit
    input  logic             mem_write_i,   // store requested
    input  logic             mem_read_i,    // load requested
    input  logic             mem_source_i,  // 1 = store from fpu reg
    input  mem_pkg::word_t   alu_addr_i,    // load/store address
    input  mem_pkg::word_t   fpu_data_i,
    input  mem_pkg::word_t   reg_data_i,
    output mem_pkg::word_t   instr_o,
    output logic             instr_valid_o,
    output mem_pkg::word_t   reg_data_o,    // extended load result
    output logic             reg_load_o,
    output logic             freeze_o,      // stall the core
    mem_req_if.producer      req
);
    import mem_pkg::*;

    handler_state_t state;
    handler_state_t state_n;
    mem_op_t        load_op_q;  // op of the load in flight
    word_t          st_src;     // fpu or reg data
    word_t          st_data;    // zero extended store data
    strb_t          st_strb;
    logic           st_ok;      // op code is a store we can issue
    logic           push_fire;
    logic           push_stall;

    // load result formatting by op code
    function automatic word_t load_extend(input word_t raw, input mem_op_t op);
        case (op)
            OP_LB:   return {{24{raw[7]}}, raw[7:0]};
            OP_LH:   return {{16{raw[15]}}, raw[15:0]};
            OP_LW:   return raw;
            OP_LBU:  return {24'b0, raw[7:0]};
            OP_LHU:  return {16'b0, raw[15:0]};
            default: return '0;     // not a load
        endcase
    endfunction

    // store data and strobe
    always_comb begin
        st_src = mem_source_i ? fpu_data_i : reg_data_i;
        case (mem_op_i)
            OP_SB: begin
                st_data = {24'b0, st_src[7:0]};
                st_strb = STRB_BYTE;
                st_ok   = 1'b1;
            end
            OP_SH: begin
                st_data = {16'b0, st_src[15:0]};
                st_strb = STRB_HALF;
                st_ok   = 1'b1;
            end
            OP_SW: begin
                st_data = st_src;
                st_strb = STRB_WORD;
                st_ok   = 1'b1;
            end
            default: begin
                st_data = '0;
                st_strb = '0;
                st_ok   = 1'b0;     // no write issued
            end
        endcase
    end

    // request build and next state
    always_comb begin
        state_n        = state;
        req.push_valid = 1'b0;
        req.push_write = 1'b0;
        req.push_addr  = alu_addr_i;
        req.push_wdata = '0;
        req.push_strb  = '0;        // reads carry no strobe
        case (state)
            FETCH: begin
                req.push_valid = 1'b1;
                req.push_addr  = pc_i;
                if (req.push_ready) state_n = F_WAIT;
            end
            F_WAIT: begin
                if (req.rsp_valid) state_n = DATA;
            end
            DATA: begin
                if (mem_write_i) begin
                    if (st_ok) begin
                        req.push_valid = 1'b1;
                        req.push_write = 1'b1;
                        req.push_wdata = st_data;
                        req.push_strb  = st_strb;
                        if (req.push_ready) state_n = FETCH;    // posted, no wait
                    end else begin
                        state_n = FETCH;
                    end
                end else if (mem_read_i) begin
                    req.push_valid = 1'b1;
                    if (req.push_ready) state_n = D_WAIT;
                end else begin
                    state_n = FETCH;    // no memory op this instr
                end
            end
            D_WAIT: begin
                if (req.rsp_valid) state_n = FETCH;
            end
            default: state_n = FETCH;
        endcase
    end

    assign push_fire  = req.push_valid && req.push_ready;
    assign push_stall = req.push_valid && !req.push_ready;   // fifo full
    assign freeze_o   = (state == F_WAIT) || (state == D_WAIT) || push_stall;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state         <= FETCH;
            instr_valid_o <= 1'b0;
            reg_load_o    <= 1'b0;
        end else begin
            state         <= state_n;
            instr_valid_o <= (state == F_WAIT) && req.rsp_valid;  // one cycle in DATA
            reg_load_o    <= (state == D_WAIT) && req.rsp_valid;
        end
    end

    // payload regs
    always_ff @(posedge clk) begin
        if ((state == F_WAIT) && req.rsp_valid) instr_o <= req.rsp_rdata;
        if ((state == D_WAIT) && req.rsp_valid) reg_data_o <= load_extend(req.rsp_rdata, load_op_q);
        if ((state == DATA) && push_fire && !req.push_write) load_op_q <= mem_op_i;
    end

endmodule

/* source/mem_req_fifo.sv */
`timescale 1ns/1ps

module mem_req_fifo (
    input  logic      clk,
    input  logic      nrst,
    mem_req_if.buffer req
);
    import mem_pkg::*;

    logic             wr_mem    [FIFO_DEPTH];   // write flag per entry
    word_t            addr_mem  [FIFO_DEPTH];
    word_t            wdata_mem [FIFO_DEPTH];
    strb_t            strb_mem  [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                    // entries held
    logic             push_fire;
    logic             pop_fire;

    assign req.push_ready = (count != CNT_W'(FIFO_DEPTH));  // low only when full
    assign req.pop_valid  = (count != '0);
    assign push_fire      = req.push_valid && req.push_ready;
    assign pop_fire       = req.pop_valid && req.pop_ready;

    // head entry straight out
    assign req.pop_write = wr_mem[rd_ptr];
    assign req.pop_addr  = addr_mem[rd_ptr];
    assign req.pop_wdata = wdata_mem[rd_ptr];
    assign req.pop_strb  = strb_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) wr_ptr <= wr_ptr + 1'b1;     // wraps at depth
            if (pop_fire) rd_ptr <= rd_ptr + 1'b1;
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push_fire) begin
            wr_mem[wr_ptr]    <= req.push_write;
            addr_mem[wr_ptr]  <= req.push_addr;
            wdata_mem[wr_ptr] <= req.push_wdata;
            strb_mem[wr_ptr]  <= req.push_strb;
        end
    end

endmodule

/* source/apb_mem_master.sv */
`timescale 1ns/1ps

module apb_mem_master (
    input  logic           clk,
    input  logic           nrst,
    input  mem_pkg::word_t prdata_i,
    input  logic           pready_i,
    output mem_pkg::word_t paddr_o,
    output logic           psel_o,
    output logic           penable_o,
    output logic           pwrite_o,
    output mem_pkg::word_t pwdata_o,
    output mem_pkg::strb_t pstrb_o,
    mem_req_if.consumer    req
);
    import mem_pkg::*;

    apb_state_t state;
    word_t      addr_q;     // held for whole transfer
    word_t      wdata_q;
    strb_t      strb_q;
    logic       write_q;
    logic       pop_fire;
    logic       done;       // access phase accepted

    // take a request only when the bus is free and one is queued
    assign req.pop_ready = (state == IDLE) && req.pop_valid;
    assign pop_fire      = req.pop_valid && req.pop_ready;
    assign done          = (state == ACCESS) && pready_i;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state         <= IDLE;
            req.rsp_valid <= 1'b0;
        end else begin
            req.rsp_valid <= done && !write_q;  // reads only
            case (state)
                IDLE: begin
                    if (pop_fire) state <= SETUP;
                end
                SETUP:   state <= ACCESS;
                ACCESS: begin
                    if (pready_i) state <= IDLE;    // else wait state
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request fields and read data capture
    always_ff @(posedge clk) begin
        if (pop_fire) begin
            addr_q  <= req.pop_addr;
            write_q <= req.pop_write;
            wdata_q <= req.pop_wdata;
            strb_q  <= req.pop_write ? req.pop_strb : '0;   // reads drive zero strobe
        end
        if (done && !write_q) req.rsp_rdata <= prdata_i;
    end

    assign psel_o    = (state != IDLE);
    assign penable_o = (state == ACCESS);
    assign paddr_o   = addr_q;
    assign pwrite_o  = write_q;
    assign pwdata_o  = wdata_q;
    assign pstrb_o   = strb_q;

endmodule

/* source/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic             clk,
    input  logic             nrst,
    // cpu side
    input  mem_pkg::word_t   pc_i,
    input  mem_pkg::mem_op_t mem_op_i,
    input  logic             mem_write_i,
    input  logic             mem_read_i,
    input  logic             mem_source_i,
    input  mem_pkg::word_t   alu_addr_i,
    input  mem_pkg::word_t   fpu_data_i,
    input  mem_pkg::word_t   reg_data_i,
    output mem_pkg::word_t   instr_o,
    output logic             instr_valid_o,
    output mem_pkg::word_t   reg_data_o,
    output logic             reg_load_o,
    output logic             freeze_o,
    // apb side
    output mem_pkg::word_t   paddr_o,
    output logic             psel_o,
    output logic             penable_o,
    output logic             pwrite_o,
    output mem_pkg::word_t   pwdata_o,
    output mem_pkg::strb_t   pstrb_o,
    input  mem_pkg::word_t   prdata_i,
    input  logic             pready_i
);

    mem_req_if u_req_if (.clk(clk));   // handler -> fifo -> master

    mem_handler u_handler (
        .clk           (clk),
        .nrst          (nrst),
        .pc_i          (pc_i),
        .mem_op_i      (mem_op_i),
        .mem_write_i   (mem_write_i),
        .mem_read_i    (mem_read_i),
        .mem_source_i  (mem_source_i),
        .alu_addr_i    (alu_addr_i),
        .fpu_data_i    (fpu_data_i),
        .reg_data_i    (reg_data_i),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .reg_data_o    (reg_data_o),
        .reg_load_o    (reg_load_o),
        .freeze_o      (freeze_o),
        .req           (u_req_if.producer)
    );

    mem_req_fifo u_fifo (
        .clk  (clk),
        .nrst (nrst),
        .req  (u_req_if.buffer)
    );

    apb_mem_master u_apb (
        .clk       (clk),
        .nrst      (nrst),
        .prdata_i  (prdata_i),
        .pready_i  (pready_i),
        .paddr_o   (paddr_o),
        .psel_o    (psel_o),
        .penable_o (penable_o),
        .pwrite_o  (pwrite_o),
        .pwdata_o  (pwdata_o),
        .pstrb_o   (pstrb_o),
        .req       (u_req_if.consumer)
    );

endmodule

/* verification/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_pkg::*;

    logic     clk = 1'b0;
    logic     nrst;
    word_t    pc_i;
    mem_op_t  mem_op_i;
    logic     mem_write_i;
    logic     mem_read_i;
    logic     mem_source_i;
    word_t    alu_addr_i;
    word_t    fpu_data_i;
    word_t    reg_data_i;
    word_t    instr_o;
    logic     instr_valid_o;
    word_t    reg_data_o;
    logic     reg_load_o;
    logic     freeze_o;
    word_t    paddr_o;
    logic     psel_o;
    logic     penable_o;
    logic     pwrite_o;
    word_t    pwdata_o;
    strb_t    pstrb_o;
    word_t    prdata_i;
    logic     pready_i;

    word_t       mem [64];                  // apb slave storage indexed by paddr[7:2]
    logic [68:0] exp_q [$];                 // {write, addr, data, strb} in issue order
    mem_op_t     load_ops [5] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    word_t       exp_instr;                 // model word at current pc
    word_t       exp_load;                  // extended value of load in flight
    word_t       last_data;
    int          seed = 6;
    int          wait_left;                 // wait states left in this transfer
    logic        long_wait;                 // hold pready low for a long time
    logic        in_reset_q = 1'b0;         // reset seen at previous edge
    logic        freeze_q = 1'b0;           // freeze_o at previous edge
    int          error_count;
    int          errors_before;
    int          tests_ok;
    int          tests_bad;

    mem_subsys_top dut (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input word_t got, input word_t want);
        $display("** Error: %0t: %s, got %h expected %h", $time, what, got, want);
        error_count++;
    endtask

    task automatic abort_run(input string what);
        $display("timed out waiting for %s at %0t", what, $time);
        $display("Test failed");
        $finish;
    endtask

    function automatic strb_t store_strb(input mem_op_t op);
        case (op)
            OP_SB:   return 4'b0001;
            OP_SH:   return 4'b0011;
            OP_SW:   return 4'b1111;
            default: return 4'b0000;        // not a store
        endcase
    endfunction

    // keep only the lanes the strobe writes
    function automatic word_t store_data(input word_t src, input mem_op_t op);
        strb_t s;
        s = store_strb(op);
        return src & {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    function automatic word_t extend_rule(input word_t w, input mem_op_t op);
        case (op)
            OP_LB:   return w[7] ? (w | 32'hFFFF_FF00) : (w & 32'h0000_00FF);
            OP_LH:   return w[15] ? (w | 32'hFFFF_0000) : (w & 32'h0000_FFFF);
            OP_LW:   return w;
            OP_LBU:  return w & 32'h0000_00FF;
            OP_LHU:  return w & 32'h0000_FFFF;
            default: return 32'h0;
        endcase
    endfunction

    // apb slave with random or long wait states
    always @(negedge clk) begin
        pready_i = 1'b0;
        if (psel_o && !penable_o) begin
            wait_left = long_wait ? 6 : {$random(seed)} % 4;
        end else if (psel_o && penable_o) begin
            if (wait_left == 0) begin
                pready_i = 1'b1;
                prdata_i = mem[paddr_o[7:2]];
                if (pwrite_o) begin
                    for (int b = 0; b < 4; b++) begin
                        if (pstrb_o[b]) mem[paddr_o[7:2]][8*b +: 8] = pwdata_o[8*b +: 8];
                    end
                end
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    // transfer monitor checks issue order
    always @(posedge clk) begin
        in_reset_q <= !nrst;
        freeze_q   <= freeze_o;
        if (nrst && psel_o && penable_o && pready_i) begin
            if (exp_q.size() == 0) begin
                $display("unexpected APB transfer to %h at %0t", paddr_o, $time);
                error_count++;
            end else begin
                xfer_match: assert (exp_q[0][68] == pwrite_o && exp_q[0][67:36] == paddr_o
                                    && exp_q[0][3:0] == pstrb_o
                                    && (!pwrite_o || exp_q[0][35:4] == pwdata_o))
                    else report_mismatch("apb transfer fields, address", paddr_o,
                                         exp_q[0][67:36]);
                void'(exp_q.pop_front());
            end
        end
    end

    reset_quiet: assert property (@(posedge clk)
        in_reset_q |-> (!psel_o && !penable_o && !instr_valid_o && !reg_load_o))
        else report_mismatch("outputs active in reset",
                             {28'b0, psel_o, penable_o, instr_valid_o, reg_load_o}, 32'h0);
    fetch_word: assert property (@(posedge clk) disable iff (!nrst)
        instr_valid_o |-> (instr_o == exp_instr))
        else report_mismatch("fetched word", instr_o, exp_instr);
    load_value: assert property (@(posedge clk) disable iff (!nrst)
        reg_load_o |-> (reg_data_o == exp_load))
        else report_mismatch("load result", reg_data_o, exp_load);
    freeze_on_stall: assert property (@(posedge clk) disable iff (!nrst)
        (psel_o && penable_o && !pready_i) |-> freeze_o)
        else report_mismatch("freeze_o during bus stall", {31'b0, freeze_o}, 32'h1);
    read_strobe: assert property (@(posedge clk) disable iff (!nrst)
        (psel_o && !pwrite_o) |-> (pstrb_o == 4'b0))
        else report_mismatch("read strobe", {28'b0, pstrb_o}, 32'h0);

    // kind 0 fetch done, 1 load done, 2 push taken, 3 bus drained
    task automatic wait_until(input int kind, input string what);
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit) begin
            @(negedge clk);
            n++;
            case (kind)
                0:       hit = instr_valid_o;
                1:       hit = reg_load_o;
                2:       hit = !freeze_q;
                default: hit = (exp_q.size() == 0);
            endcase
            if (!hit && n >= 300) abort_run(what);
        end
    endtask

    task automatic next_fetch();
        mem_op_i    = OP_NONE;
        mem_write_i = 1'b0;
        mem_read_i  = 1'b0;
        pc_i        = (pc_i + 32'd4) & 32'h0000_007C;   // program in words 0..31
        exp_instr   = mem[pc_i[7:2]];
        exp_q.push_back({1'b0, pc_i, 32'h0, 4'h0});
    endtask

    // answer one instr_valid_o with a data op
    task automatic run_instr(input mem_op_t op, input logic wr, input logic rd,
                             input logic from_fpu, input word_t addr, input word_t rdat,
                             input word_t fdat, input word_t load_word);
        word_t src;
        wait_until(0, "instr_valid_o");
        mem_op_i     = op;
        mem_write_i  = wr;
        mem_read_i   = rd;
        mem_source_i = from_fpu;
        alu_addr_i   = addr;
        reg_data_i   = rdat;
        fpu_data_i   = fdat;
        src          = from_fpu ? fdat : rdat;
        if (wr && store_strb(op) != 4'b0) begin
            exp_q.push_back({1'b1, addr, store_data(src, op), store_strb(op)});
        end else if (!wr && rd) begin
            exp_q.push_back({1'b0, addr, 32'h0, 4'h0});
            exp_load = extend_rule(load_word, op);
        end
        if (!wr && rd) begin
            wait_until(1, "reg_load_o");
        end else begin
            wait_until(2, "store push");
        end
        next_fetch();
    endtask

    task automatic finish_test(input string name);
        if (error_count == errors_before) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: FAILED, %0d errors", name, error_count - errors_before);
            tests_bad++;
        end
        errors_before = error_count;
    endtask

    initial begin
        #1_000_000;
        $display("simulation ran past its time limit");
        $display("Test failed");
        $finish;
    end

    initial begin
        nrst          = 1'b0;
        pc_i          = 32'h0;
        mem_op_i      = OP_NONE;
        mem_write_i   = 1'b0;
        mem_read_i    = 1'b0;
        mem_source_i  = 1'b0;
        alu_addr_i    = 32'h0;
        fpu_data_i    = 32'h0;
        reg_data_i    = 32'h0;
        prdata_i      = 32'h0;
        pready_i      = 1'b0;
        long_wait     = 1'b0;
        exp_load      = 32'h0;
        error_count   = 0;
        errors_before = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        for (int i = 0; i < 64; i++) mem[i] = (word_t'(i) << 2) * 32'h9E37_79B1 ^ 32'h00C3_5A00;
        mem[40]   = 32'h1234_8A9C;              // byte and half sign bits set
        mem[41]   = 32'h7E5D_3A41;              // both clear
        exp_instr = mem[0];
        exp_q.push_back({1'b0, 32'h0, 32'h0, 4'h0});    // first fetch at pc 0
        repeat (4) @(negedge clk);
        nrst = 1'b1;

        run_instr(OP_NONE, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 32'h0);
        finish_test("reset state");

        repeat (6) run_instr(OP_NONE, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 32'h0);
        finish_test("instruction fetch");

        run_instr(OP_SB, 1'b1, 1'b0, 1'b0, 32'h80, 32'hDEAD_BEEF, 32'hC1A5_F00D, 32'h0);
        run_instr(OP_SH, 1'b1, 1'b0, 1'b0, 32'h84, 32'hDEAD_BEEF, 32'hC1A5_F00D, 32'h0);
        run_instr(OP_SW, 1'b1, 1'b0, 1'b0, 32'h88, 32'hDEAD_BEEF, 32'hC1A5_F00D, 32'h0);
        run_instr(OP_SB, 1'b1, 1'b0, 1'b1, 32'h8C, 32'hDEAD_BEEF, 32'hC1A5_F00D, 32'h0);
        run_instr(OP_SH, 1'b1, 1'b0, 1'b1, 32'h90, 32'hDEAD_BEEF, 32'hC1A5_F00D, 32'h0);
        run_instr(OP_SW, 1'b1, 1'b0, 1'b1, 32'h94, 32'hDEAD_BEEF, 32'hC1A5_F00D, 32'h0);
        run_instr(OP_NONE, 1'b1, 1'b0, 1'b0, 32'h98, 32'hDEAD_BEEF, 32'hC1A5_F00D, 32'h0);
        finish_test("store formatting");

        for (int a = 40; a < 42; a++) begin
            for (int k = 0; k < 5; k++) begin
                run_instr(load_ops[k], 1'b0, 1'b1, 1'b0, word_t'(a) << 2, 32'h0, 32'h0, mem[a]);
            end
        end
        finish_test("load extension");

        long_wait = 1'b1;                       // every transfer waits 6 cycles
        repeat (4) begin
            last_data = $random(seed);
            run_instr(OP_SW, 1'b1, 1'b0, 1'b0, 32'hC0, last_data, ~last_data, 32'h0);
        end
        run_instr(OP_LH, 1'b0, 1'b1, 1'b0, 32'hC0, 32'h0, 32'h0, last_data);
        long_wait = 1'b0;
        finish_test("posted order and stall");

        wait_until(3, "last APB transfer");
        $display("tests ok: %0d, tests failing: %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
source/mem_pkg.sv
source/mem_req_if.sv
source/mem_handler.sv
source/mem_req_fifo.sv
source/apb_mem_master.sv
source/mem_subsys_top.sv
verification/tb_mem_subsys.sv

/* Makefile */
BIN  := obj_dir/Vtb_mem_subsys
SRCS := $(wildcard source/*.sv) verification/tb_mem_subsys.sv

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

$(BIN): $(SRCS) compile.f
	verilator --binary --assert --top-module tb_mem_subsys -f compile.f -o Vtb_mem_subsys

clean:
	rm -rf obj_dir
